// File: hw/cray_pkg.sv
/*
 * cray core shared types: widths, package constants, opcode and
 * exchange state encodings, and the control structs between blocks
 */
`default_nettype none

package cray_pkg;

   typedef logic [15:0] parcel_t;   // one instruction parcel
   typedef logic [23:0] addr_t;     // address / A register value
   typedef logic [63:0] word_t;     // memory word
   typedef logic [7:0]  xa_t;       // exchange address
   typedef logic [6:0]  vl_t;       // vector length

   localparam int            XP_WORDS    = 16;   // words per exchange package
   localparam int            XP_CNT_W    = 4;
   localparam vl_t           VL_RESET    = 7'd64;
   localparam logic [17:0]   LIMIT_RESET = 18'h3FFFF;

   // octal opcodes, parcel bits 15:9
   typedef enum logic [6:0] {
      OP_EXCH0  = 7'o000,
      OP_SET_VL = 7'o002,
      OP_EXCH4  = 7'o004,
      OP_IMM22  = 7'o020,   // two parcels
      OP_IMM6   = 7'o022,
      OP_AADD   = 7'o030,
      OP_ASUB   = 7'o031
   } opcode_e;

   typedef enum logic [2:0] {
      XP_EXECUTE,
      XP_CLEAR_IBUF,
      XP_FETCH,
      XP_LOAD_WAIT,
      XP_STORE,
      XP_LOAD,
      XP_DONE
   } xp_state_e;

   typedef struct packed {
      xp_state_e             state;
      logic [XP_CNT_W-1:0]   cnt;     // package word index
      logic                  store;   // store burst active
      logic                  load;    // load burst active
   } xp_ctl_t;

   typedef struct packed {
      logic          wr_en;
      opcode_e       op;
      logic [2:0]    i;
      logic [2:0]    j;
      logic [2:0]    k;
      logic [21:0]   imm22;
   } a_op_t;

endpackage

`default_nettype wire

// File: hw/xp_sequencer.sv
/*
 * exchange package sequencer: state machine, package word counter
 * and steering of the memory port between execute and package transfer
 */
`timescale 1ns/1ns
`default_nettype none

module xp_sequencer import cray_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  wire      i_nip_vld,
   input  wire      i_exch_req,
   input  addr_t    i_p,
   input  xa_t      i_xa,
   input  word_t    i_store_word,
   output xp_ctl_t  o_ctl,
   output xa_t      o_active_xa,
   output logic     o_clear_ibufs,
   output addr_t    o_p_addr,
   output logic     o_mem_ce,
   output logic     o_mem_wr_en,
   output word_t    o_data_to_mem
);

   localparam logic [XP_CNT_W-1:0] CNT_LAST = XP_CNT_W'(XP_WORDS - 1);

   xp_state_e            state;
   logic [XP_CNT_W-1:0]  cnt;
   xa_t                  active_xa;
   logic                 storing;

   //////////////////////////////////////////////////////////////////////
   // state machine and word counter
   always_ff @(posedge clk)
   begin
      if (rst)
         state <= XP_CLEAR_IBUF;    // reset runs a full exchange
      else
         case (state)
            XP_EXECUTE:    if (i_exch_req) state <= XP_CLEAR_IBUF;
            XP_CLEAR_IBUF: state <= XP_FETCH;
            XP_FETCH:      if (i_nip_vld) state <= XP_LOAD_WAIT;   // package ready
            XP_LOAD_WAIT:  state <= XP_STORE;
            XP_STORE:      if (cnt == CNT_LAST) state <= XP_LOAD;
            XP_LOAD:       if (cnt == CNT_LAST) state <= XP_DONE;
            default:       state <= XP_EXECUTE;    // XP_DONE
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         cnt <= '0;
      else if (state == XP_STORE || state == XP_LOAD)
         cnt <= cnt + 1'b1;    // wraps to 0 between bursts
      else
         cnt <= '0;
   end

   // exchange address in use for this package transfer
   always_ff @(posedge clk)
   begin
      if (rst)
         active_xa <= '0;
      else if (state == XP_EXECUTE)
         active_xa <= i_xa;
   end

   //////////////////////////////////////////////////////////////////////
   // memory port
   assign storing       = (state == XP_STORE);
   assign o_ctl         = '{state: state, cnt: cnt, store: storing, load: state == XP_LOAD};
   assign o_active_xa   = active_xa;
   assign o_clear_ibufs = (state == XP_CLEAR_IBUF) || (state == XP_DONE);
   assign o_p_addr      = (state == XP_EXECUTE) ? i_p : {10'b0, active_xa, cnt, 2'b00};
   assign o_mem_ce      = storing;
   assign o_mem_wr_en   = storing;
   assign o_data_to_mem = storing ? i_store_word : '0;

endmodule

`default_nettype wire

// File: hw/parcel_issue.sv
/*
 * parcel pipeline (nip/cip/lip), two-parcel detect, decode of the
 * current parcel, and the program counter
 */
`timescale 1ns/1ns
`default_nettype none

module parcel_issue import cray_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  xp_ctl_t  i_ctl,
   input  parcel_t  i_nip_nxt,
   input  wire      i_nip_vld,
   input  word_t    i_word_nxt,
   output a_op_t    o_a_op,
   output logic     o_exch_req,
   output logic     o_set_vl,
   output logic     o_k_zero,
   output addr_t    o_p
);

   parcel_t  nip, cip, lip;
   logic     nip_vld, cip_vld, lip_vld;
   logic     two_parcel_nip;
   logic     shift;
   logic     a_wr;
   opcode_e  op;
   addr_t    p_addr;

   assign op             = opcode_e'(cip[15:9]);
   assign two_parcel_nip = nip_vld && (nip[15:9] == OP_IMM22);
   assign o_exch_req     = cip_vld && (op == OP_EXCH0 || op == OP_EXCH4);
   // the current parcel issues as the pipe advances
   assign shift          = (i_ctl.state == XP_EXECUTE) && i_nip_vld && !o_exch_req;

   always_ff @(posedge clk)
   begin
      if (rst || i_ctl.state == XP_DONE)
      begin
         nip     <= '0;
         cip     <= '0;
         lip     <= '0;
         nip_vld <= 1'b0;
         cip_vld <= 1'b0;
         lip_vld <= 1'b0;
      end
      else if (shift)
      begin
         nip     <= two_parcel_nip ? '0 : i_nip_nxt;   // trailing parcel skips nip
         lip     <= i_nip_nxt;
         cip     <= nip;
         nip_vld <= !two_parcel_nip;
         cip_vld <= nip_vld;
         lip_vld <= two_parcel_nip;    // lip belongs to the new cip
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // decode
   always_comb
   begin
      case (op)
         OP_IMM6, OP_AADD, OP_ASUB: a_wr = 1'b1;
         OP_IMM22:                  a_wr = lip_vld;
         default:                   a_wr = 1'b0;
      endcase
   end

   assign o_a_op   = '{wr_en: shift && cip_vld && a_wr, op: op, i: cip[8:6],
                       j: cip[5:3], k: cip[2:0], imm22: {cip[5:0], lip}};
   assign o_set_vl = shift && cip_vld && (op == OP_SET_VL);
   assign o_k_zero = (cip[2:0] == 3'd0);

   // program counter, one step per accepted parcel
   always_ff @(posedge clk)
   begin
      if (rst)
         p_addr <= '0;
      else if (shift)
         p_addr <= p_addr + 1'b1;
      else if (i_ctl.load && i_ctl.cnt == '0)
         p_addr <= i_word_nxt[47:24];
   end

   assign o_p = p_addr;

endmodule

`default_nettype wire

// File: hw/addr_unit.sv
/*
 * address unit: eight A registers with add/subtract and immediate
 * writes, plus the exchange package read and load port
 */
`timescale 1ns/1ns
`default_nettype none

module addr_unit import cray_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  xp_ctl_t  i_ctl,
   input  a_op_t    i_a_op,
   input  word_t    i_word_nxt,
   output addr_t    o_ak,
   output addr_t    o_ex_data
);

   addr_t  a_rf [8];
   addr_t  aj, ak;
   addr_t  result;
   logic   xp_wr;

   // A0 as an operand reads as zero
   assign aj = (i_a_op.j == 3'd0) ? '0 : a_rf[i_a_op.j];
   assign ak = (i_a_op.k == 3'd0) ? '0 : a_rf[i_a_op.k];

   always_comb
   begin
      case (i_a_op.op)
         OP_AADD:  result = aj + ak;    // wraps at 24 bits
         OP_ASUB:  result = aj - ak;
         OP_IMM6:  result = {18'b0, i_a_op.j, i_a_op.k};
         OP_IMM22: result = {2'b0, i_a_op.imm22};
         default:  result = '0;
      endcase
   end

   // package words 0..7 carry A0..A7
   assign xp_wr = i_ctl.load && !i_ctl.cnt[3];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int n = 0; n < 8; n++)
            a_rf[n] <= '0;
      end
      else if (xp_wr)
         a_rf[i_ctl.cnt[2:0]] <= i_word_nxt[23:0];
      else if (i_a_op.wr_en)
         a_rf[i_a_op.i] <= result;
   end

   assign o_ak      = ak;
   assign o_ex_data = a_rf[i_ctl.cnt[2:0]];   // store side of the package

endmodule

`default_nettype wire

// File: hw/xp_context.sv
/*
 * context registers (base, limit, exchange address, vector length)
 * and assembly of the package word to store
 */
`timescale 1ns/1ns
`default_nettype none

module xp_context import cray_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  xp_ctl_t  i_ctl,
   input  word_t    i_word_nxt,
   input  wire      i_set_vl,
   input  addr_t    i_ak,
   input  wire      i_k_zero,
   input  addr_t    i_p,
   input  addr_t    i_ex_data,
   input  xa_t      i_active_xa,
   output xa_t      o_xa,
   output word_t    o_store_word
);

   logic [17:0]  base_addr;
   logic [17:0]  limit_addr;
   xa_t          xa;
   vl_t          vl;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         base_addr  <= '0;
         limit_addr <= LIMIT_RESET;
         xa         <= '0;
         vl         <= VL_RESET;
      end
      else if (i_ctl.load)
      begin
         if (i_ctl.cnt == 4'd1) base_addr  <= i_word_nxt[45:28];
         if (i_ctl.cnt == 4'd2) limit_addr <= i_word_nxt[45:28];
         if (i_ctl.cnt == 4'd3)
         begin
            xa <= i_word_nxt[47:40];
            vl <= i_word_nxt[39:33];
         end
      end
      else if (i_set_vl)
         vl <= i_k_zero ? 7'd1 : i_ak[6:0];   // k of zero means length 1
   end

   assign o_xa = xa;

   //////////////////////////////////////////////////////////////////////
   // store word for the current counter
   always_comb
   begin
      case (i_ctl.cnt)
         4'd0:    o_store_word = {16'b0, i_p, i_ex_data};
         4'd1:    o_store_word = {18'b0, base_addr, 4'b0, i_ex_data};
         4'd2:    o_store_word = {18'b0, limit_addr, 4'b0, i_ex_data};
         4'd3:    o_store_word = {16'b0, i_active_xa, vl, 9'b0, i_ex_data};
         4'd4, 4'd5, 4'd6, 4'd7:
                  o_store_word = {40'b0, i_ex_data};
         default: o_store_word = '0;    // S register slots not kept
      endcase
   end

endmodule

`default_nettype wire

// File: hw/cray_core_top.sv
/*
 * cray core control top: exchange sequencer with parcel issue,
 * address unit and context register datapaths around it
 */
`timescale 1ns/1ns
`default_nettype none

module cray_core_top import cray_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  parcel_t  i_nip_nxt,
   input  word_t    i_word_nxt,
   input  wire      i_nip_vld,
   output addr_t    o_p_addr,
   output logic     o_clear_ibufs,
   output logic     o_mem_ce,
   output word_t    o_data_to_mem,
   output logic     o_mem_wr_en
);

   xp_ctl_t  ctl;
   a_op_t    a_op;
   logic     exch_req;
   logic     set_vl;
   logic     k_zero;
   addr_t    p_addr;
   addr_t    ak;
   addr_t    ex_data;
   xa_t      xa;
   xa_t      active_xa;
   word_t    store_word;

   xp_sequencer u_seq (
      .clk           (clk),
      .rst           (rst),
      .i_nip_vld     (i_nip_vld),
      .i_exch_req    (exch_req),
      .i_p           (p_addr),
      .i_xa          (xa),
      .i_store_word  (store_word),
      .o_ctl         (ctl),
      .o_active_xa   (active_xa),
      .o_clear_ibufs (o_clear_ibufs),
      .o_p_addr      (o_p_addr),
      .o_mem_ce      (o_mem_ce),
      .o_mem_wr_en   (o_mem_wr_en),
      .o_data_to_mem (o_data_to_mem)
   );

   parcel_issue u_issue (
      .clk        (clk),
      .rst        (rst),
      .i_ctl      (ctl),
      .i_nip_nxt  (i_nip_nxt),
      .i_nip_vld  (i_nip_vld),
      .i_word_nxt (i_word_nxt),
      .o_a_op     (a_op),
      .o_exch_req (exch_req),
      .o_set_vl   (set_vl),
      .o_k_zero   (k_zero),
      .o_p        (p_addr)
   );

   addr_unit u_addr (
      .clk        (clk),
      .rst        (rst),
      .i_ctl      (ctl),
      .i_a_op     (a_op),
      .i_word_nxt (i_word_nxt),
      .o_ak       (ak),
      .o_ex_data  (ex_data)
   );

   xp_context u_ctx (
      .clk          (clk),
      .rst          (rst),
      .i_ctl        (ctl),
      .i_word_nxt   (i_word_nxt),
      .i_set_vl     (set_vl),
      .i_ak         (ak),
      .i_k_zero     (k_zero),
      .i_p          (p_addr),
      .i_ex_data    (ex_data),
      .i_active_xa  (active_xa),
      .o_xa         (xa),
      .o_store_word (store_word)
   );

endmodule

`default_nettype wire

// File: bench/cray_core_sva.sv
/*
 * sequencer timing assertions, bound to xp_sequencer
 */
`timescale 1ns/1ns
`default_nettype none

module cray_core_sva import cray_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  xp_ctl_t  i_ctl,
   input  wire      i_mem_ce,
   input  wire      i_mem_wr_en,
   input  wire      i_clear_ibufs
);

   int  store_run;   // consecutive store cycles so far
   int  fail_cnt;

   initial fail_cnt = 0;

   always_ff @(posedge clk)
   begin
      if (rst)
         store_run <= 0;
      else if (i_mem_ce && i_mem_wr_en)
         store_run <= store_run + 1;
      else
         store_run <= 0;
   end

   //////////////////////////////////////////////////////////////////////
   a_burst_len: assert property (@(posedge clk) disable iff (rst)
      $fell(i_mem_ce) |-> (store_run == XP_WORDS))
      else
      begin
         fail_cnt++;
         $error("store burst did not last one full package");
      end

   a_clear_pulse: assert property (@(posedge clk) disable iff (rst)
      i_clear_ibufs |=> !i_clear_ibufs)
      else
      begin
         fail_cnt++;
         $error("buffer clear held for more than one cycle");
      end

   // wraps to 0 after word 15
   a_cnt_step: assert property (@(posedge clk) disable iff (rst)
      (i_ctl.store || i_ctl.load) |=> (i_ctl.cnt == $past(i_ctl.cnt) + 4'd1))
      else
      begin
         fail_cnt++;
         $error("package word counter skipped or stalled");
      end

endmodule

`default_nettype wire

// File: bench/xp_checker.sv
/*
 * output checker: compares the memory port, clear strobe and
 * address bus of the core against the reference model every cycle
 */
`timescale 1ns/1ns
`default_nettype none

module xp_checker import cray_pkg::*;
(
   input  wire    clk,
   input  wire    i_rst,
   input  wire    i_exp_store,
   input  wire    i_exp_clear,
   input  word_t  i_exp_word,
   input  addr_t  i_exp_addr,
   input  wire    i_mem_ce,
   input  wire    i_mem_wr_en,
   input  wire    i_clear_ibufs,
   input  word_t  i_data_to_mem,
   input  addr_t  i_p_addr,
   output int     o_errors
);

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      if (actual !== expected)
      begin
         o_errors++;
         $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   initial o_errors = 0;

   // sampled on the rising edge, before the core moves on
   always @(posedge clk)
   begin
      if (!i_rst)
      begin
         compare_value("o_mem_ce", 64'(i_exp_store), 64'(i_mem_ce));
         compare_value("o_mem_wr_en", 64'(i_exp_store), 64'(i_mem_wr_en));
         compare_value("o_clear_ibufs", 64'(i_exp_clear), 64'(i_clear_ibufs));
         compare_value("o_p_addr", 64'(i_exp_addr), 64'(i_p_addr));
         if (i_exp_store)
            compare_value("o_data_to_mem", i_exp_word, i_data_to_mem);   // package word
      end
   end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
/*
 * testbench top: clock, reset, random parcel and package stimulus,
 * reference model of the core state, watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module tb_top import cray_pkg::*;
();

   localparam int           NUM_TESTS    = 16;   // exchanges including the reset one
   localparam int           PARCELS      = 24;   // parcels accepted before each exchange
   localparam int           RESET_CYCLES = 4;
   localparam int unsigned  SEED         = 32'h622789c2;
   localparam longint       WATCHDOG_NS  = longint'(NUM_TESTS * (40 + PARCELS * 4) * 20);

   logic     clk;
   logic     rst;
   logic     nip_vld;
   parcel_t  nip_nxt;
   word_t    word_nxt;
   addr_t    p_addr;
   logic     clear_ibufs;
   logic     mem_ce;
   logic     mem_wr_en;
   word_t    data_to_mem;

   // reference model state for the cycle after the last rising edge
   xp_state_e    m_state;
   logic [3:0]   m_cnt;
   addr_t        m_a [8];
   addr_t        m_p;
   logic [17:0]  m_base;
   logic [17:0]  m_limit;
   xa_t          m_xa;
   xa_t          m_axa;     // exchange address in use
   vl_t          m_vl;
   parcel_t      m_nip;
   parcel_t      m_cip;
   parcel_t      m_lip;
   logic         m_nip_v;
   logic         m_cip_v;
   logic         m_lip_v;

   logic   exp_store;
   logic   exp_clear;
   word_t  exp_word;
   addr_t  exp_addr;

   int  errors;          // mismatch count from the checker
   int  cycle;
   int  accepted;        // parcels taken in this test
   int  tests_done;
   int  tests_failed;
   int  errors_before;
   int  total;

   cray_core_top dut0 (
      .clk           (clk),
      .rst           (rst),
      .i_nip_nxt     (nip_nxt),
      .i_word_nxt    (word_nxt),
      .i_nip_vld     (nip_vld),
      .o_p_addr      (p_addr),
      .o_clear_ibufs (clear_ibufs),
      .o_mem_ce      (mem_ce),
      .o_data_to_mem (data_to_mem),
      .o_mem_wr_en   (mem_wr_en)
   );

   xp_checker check0 (
      .clk           (clk),
      .i_rst         (rst),
      .i_exp_store   (exp_store),
      .i_exp_clear   (exp_clear),
      .i_exp_word    (exp_word),
      .i_exp_addr    (exp_addr),
      .i_mem_ce      (mem_ce),
      .i_mem_wr_en   (mem_wr_en),
      .i_clear_ibufs (clear_ibufs),
      .i_data_to_mem (data_to_mem),
      .i_p_addr      (p_addr),
      .o_errors      (errors)
   );

   bind xp_sequencer cray_core_sva sva0 (
      .clk           (clk),
      .rst           (rst),
      .i_ctl         (o_ctl),
      .i_mem_ce      (o_mem_ce),
      .i_mem_wr_en   (o_mem_wr_en),
      .i_clear_ibufs (o_clear_ibufs)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;    // 20 ns period

   //////////////////////////////////////////////////////////////////////
   // reference model
   function automatic addr_t a_read(input logic [2:0] r);
      return (r == 3'd0) ? 24'd0 : m_a[r];   // A0 operand is zero
   endfunction

   function automatic parcel_t random_parcel(input logic exch);
      logic [6:0]  op;
      if (exch)
         op = ($urandom % 2 == 0) ? 7'o000 : 7'o004;
      else
         case ($urandom % 5)
            0:       op = 7'o002;
            1:       op = 7'o020;
            2:       op = 7'o022;
            3:       op = 7'o030;
            default: op = 7'o031;
         endcase
      return {op, 9'($urandom)};
   endfunction

   task automatic reset_model();
      m_state = XP_CLEAR_IBUF;
      m_cnt   = '0;
      for (int n = 0; n < 8; n++)
         m_a[n] = '0;
      m_p     = '0;
      m_base  = '0;
      m_limit = '1;
      m_xa    = '0;
      m_axa   = '0;
      m_vl    = 7'd64;
      m_nip_v = 1'b0;
      m_cip_v = 1'b0;
      m_lip_v = 1'b0;
   endtask

   task automatic execute_current();
      logic [2:0]  i;
      logic [2:0]  j;
      logic [2:0]  k;
      i = m_cip[8:6];
      j = m_cip[5:3];
      k = m_cip[2:0];
      case (m_cip[15:9])
         7'o002:  m_vl = (k == 3'd0) ? 7'd1 : m_a[k][6:0];
         7'o020:  if (m_lip_v) m_a[i] = {2'b00, m_cip[5:0], m_lip};   // jk plus trailing parcel
         7'o022:  m_a[i] = {18'd0, m_cip[5:0]};
         7'o030:  m_a[i] = a_read(j) + a_read(k);
         7'o031:  m_a[i] = a_read(j) - a_read(k);
         default: ;
      endcase
   endtask

   task automatic load_word();
      case (m_cnt)
         4'd0:    m_p = word_nxt[47:24];
         4'd1:    m_base = word_nxt[45:28];
         4'd2:    m_limit = word_nxt[45:28];
         4'd3:
         begin
            m_xa = word_nxt[47:40];
            m_vl = word_nxt[39:33];
         end
         default: ;
      endcase
      if (m_cnt < 4'd8)
         m_a[m_cnt[2:0]] = word_nxt[23:0];
   endtask

   task automatic finish_test();
      int  new_errors;
      new_errors = errors - errors_before;
      if (new_errors != 0)
         tests_failed++;
      $display("test %0d (%s) done, %0d mismatches", tests_done,
               (tests_done == 0) ? "reset exchange" : "parcel stream", new_errors);
      errors_before = errors;
      accepted      = 0;
      tests_done++;
   endtask

   // one clock of the model from the inputs sampled at the last edge
   task automatic step_model();
      xp_state_e  st;
      logic       exch;
      logic       adv;
      st   = m_state;
      exch = m_cip_v && (m_cip[15:9] == 7'o000 || m_cip[15:9] == 7'o004);
      adv  = (st == XP_EXECUTE) && nip_vld && !exch;
      if (st == XP_EXECUTE)
         m_axa = m_xa;
      if (adv)
      begin
         if (m_cip_v)
            execute_current();
         m_p = m_p + 24'd1;
         accepted++;
         if (m_nip_v && m_nip[15:9] == 7'o020)
         begin
            m_cip   = m_nip;
            m_cip_v = 1'b1;
            m_lip   = nip_nxt;    // trailing parcel that never becomes current
            m_lip_v = 1'b1;
            m_nip_v = 1'b0;
         end
         else
         begin
            m_cip   = m_nip;
            m_cip_v = m_nip_v;
            m_lip_v = 1'b0;
            m_nip   = nip_nxt;
            m_nip_v = 1'b1;
         end
      end
      case (st)
         XP_EXECUTE:    if (exch) m_state = XP_CLEAR_IBUF;
         XP_CLEAR_IBUF: m_state = XP_FETCH;
         XP_FETCH:      if (nip_vld) m_state = XP_LOAD_WAIT;
         XP_LOAD_WAIT:  m_state = XP_STORE;
         XP_STORE:      if (m_cnt == 4'(XP_WORDS - 1)) m_state = XP_LOAD;
         XP_LOAD:
         begin
            load_word();
            if (m_cnt == 4'(XP_WORDS - 1)) m_state = XP_DONE;
         end
         default:
         begin
            m_nip_v = 1'b0;
            m_cip_v = 1'b0;
            m_lip_v = 1'b0;
            m_state = XP_EXECUTE;
            finish_test();
         end
      endcase
      m_cnt = (st == XP_STORE || st == XP_LOAD) ? m_cnt + 4'd1 : 4'd0;
   endtask

   function automatic word_t package_word(input logic [3:0] n);
      word_t  w;
      w = '0;
      if (n < 4'd8)
         w[23:0] = m_a[n[2:0]];
      case (n)
         4'd0:    w[47:24] = m_p;
         4'd1:    w[45:28] = m_base;
         4'd2:    w[45:28] = m_limit;
         4'd3:
         begin
            w[47:40] = m_axa;
            w[39:33] = m_vl;
         end
         default: ;    // words 8..15 stay zero
      endcase
      return w;
   endfunction

   task automatic update_expected();
      exp_store = (m_state == XP_STORE);
      exp_clear = (m_state == XP_CLEAR_IBUF) || (m_state == XP_DONE);
      exp_word  = exp_store ? package_word(m_cnt) : '0;
      exp_addr  = (m_state == XP_EXECUTE) ? m_p : 24'(m_axa) * 24'd64 + 24'(m_cnt) * 24'd4;
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus driven on the falling edge
   initial
   begin
      void'($urandom(SEED));
      rst           = 1'b1;
      nip_vld       = 1'b0;
      nip_nxt       = '0;
      word_nxt      = '0;
      cycle         = 0;
      accepted      = 0;
      tests_done    = 0;
      tests_failed  = 0;
      errors_before = 0;
      reset_model();
      update_expected();
      while (tests_done < NUM_TESTS)
      begin
         @(negedge clk);
         if (rst)
            reset_model();
         else
            step_model();
         update_expected();
         rst      = (cycle < RESET_CYCLES - 1);   // first edge already saw reset
         nip_vld  = ($urandom % 4) != 0;
         nip_nxt  = random_parcel(accepted >= PARCELS);
         word_nxt = {$urandom, $urandom};
         cycle++;
      end
      total = errors + dut0.u_seq.sva0.fail_cnt;
      $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
               tests_done, tests_failed, errors, dut0.u_seq.sva0.fail_cnt);
      if (total == 0 && tests_failed == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout, only %0d of %0d tests finished", tests_done, NUM_TESTS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/cray_pkg.sv
hw/xp_sequencer.sv
hw/parcel_issue.sv
hw/addr_unit.sv
hw/xp_context.sv
hw/cray_core_top.sv
bench/cray_core_sva.sv
bench/xp_checker.sv
bench/tb_top.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := vlog.f

SOURCES  := $(shell grep -v '^+' $(FILELIST))
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)
